/* Bender.yml */
package:
  name: cpu_datapath

sources:
  - files:
      - rtl/lc3b_types_pkg.sv
      - rtl/lc3b_ctrl_pkg.sv
      - rtl/instruction_fetch.sv
      - rtl/instruction_decode.sv
      - rtl/execution_module.sv
      - rtl/memory_module.sv
      - rtl/flow_control.sv
      - rtl/cpu_datapath.sv
  - target: test
    files:
      - tests/tb_memory.sv
      - tests/cpu_datapath_asserts.sv
      - tests/cpu_datapath_tb.sv

/* cpu_datapath.f */
rtl/lc3b_types_pkg.sv
rtl/lc3b_ctrl_pkg.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execution_module.sv
rtl/memory_module.sv
rtl/flow_control.sv
rtl/cpu_datapath.sv
tests/tb_memory.sv
tests/cpu_datapath_asserts.sv
tests/cpu_datapath_tb.sv

/* rtl/cpu_datapath.sv */
module cpu_datapath (
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input logic resp_b,
	output lc3b_types_pkg::lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_types_pkg::lc3b_word mem_rdata1,
	output lc3b_types_pkg::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_types_pkg::lc3b_word mem_wdata2,
	input lc3b_types_pkg::lc3b_word mem_rdata2
);

	lc3b_types_pkg::lc3b_word if_ir;
	lc3b_types_pkg::lc3b_word if_pc;
	logic if_valid;
	logic fetch_busy;

	lc3b_ctrl_pkg::id_ex_t id_ex;
	lc3b_types_pkg::lc3b_nzp nzp;
	lc3b_types_pkg::lc3b_reg dec_sr1;
	lc3b_types_pkg::lc3b_reg dec_sr2;
	lc3b_ctrl_pkg::lc3b_control dec_cw;

	lc3b_ctrl_pkg::ex_mem_t ex_mem;
	logic redirect;
	lc3b_types_pkg::lc3b_word target;

	lc3b_ctrl_pkg::mem_wb_t mem_wb;
	logic mem_busy;

	logic advance_if;
	logic advance_id;
	logic stall_id;
	logic advance_ex;
	logic advance_mem;
	logic flush;

	instruction_fetch fetch_stage (.*);

	instruction_decode decode_stage (.*);

	execution_module execute_stage (.*);

	memory_module memory_stage (.*);

	flow_control hazard_unit (
		.*,
		.ex_cw(id_ex.cw),
		.mem_cw(ex_mem.cw),
		.wb_cw(mem_wb.cw)
	);

endmodule : cpu_datapath

/* rtl/execution_module.sv */
module execution_module (
	input logic clk,
	input logic rst_n,
	input lc3b_ctrl_pkg::id_ex_t id_ex,
	input lc3b_types_pkg::lc3b_nzp nzp,
	input logic advance_ex,
	output lc3b_ctrl_pkg::ex_mem_t ex_mem,
	output logic redirect,
	output lc3b_types_pkg::lc3b_word target
);

	lc3b_types_pkg::lc3b_word operand_b;
	lc3b_types_pkg::lc3b_word alu_out;

	assign operand_b = id_ex.cw.use_imm ? id_ex.offset : id_ex.sr2;

	always_comb begin
		case (id_ex.cw.alu_op)
			lc3b_ctrl_pkg::alu_add: alu_out = id_ex.sr1 + operand_b;
			lc3b_ctrl_pkg::alu_and: alu_out = id_ex.sr1 & operand_b;
			lc3b_ctrl_pkg::alu_not: alu_out = id_ex.sr1 ^ operand_b;
			default: alu_out = operand_b;
		endcase
	end

	// Decode holds a branch until no older instruction can still change nzp
	assign target = id_ex.pc + id_ex.offset;
	assign redirect = id_ex.cw.valid && id_ex.cw.is_branch && |(id_ex.cw.dest & nzp);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else if (advance_ex) begin
			ex_mem.cw <= id_ex.cw;
			ex_mem.alu <= alu_out;
			ex_mem.store_data <= id_ex.sr2;
		end
	end

endmodule : execution_module

/* rtl/flow_control.sv */
module flow_control (
	input lc3b_types_pkg::lc3b_reg dec_sr1,
	input lc3b_types_pkg::lc3b_reg dec_sr2,
	input lc3b_ctrl_pkg::lc3b_control dec_cw,
	input lc3b_ctrl_pkg::lc3b_control ex_cw,
	input lc3b_ctrl_pkg::lc3b_control mem_cw,
	input lc3b_ctrl_pkg::lc3b_control wb_cw,
	input logic fetch_busy,
	input logic mem_busy,
	input logic redirect,
	output logic advance_if,
	output logic advance_id,
	output logic stall_id,
	output logic advance_ex,
	output logic advance_mem,
	output logic flush
);

	lc3b_ctrl_pkg::lc3b_control ahead [3];
	logic [2:0] conflict;
	logic uses_sr1;
	logic uses_sr2;
	logic hazard;

	assign ahead[0] = ex_cw;
	assign ahead[1] = mem_cw;
	assign ahead[2] = wb_cw;

	assign uses_sr1 = !dec_cw.is_branch;
	assign uses_sr2 = dec_cw.mem_write || (!dec_cw.use_imm && !dec_cw.is_branch);

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			conflict[i] = ahead[i].valid &&
				((ahead[i].load_reg && ((uses_sr1 && ahead[i].dest == dec_sr1) ||
				(uses_sr2 && ahead[i].dest == dec_sr2))) ||
				(dec_cw.is_branch && ahead[i].set_cc));
		end
	end

	assign hazard = dec_cw.valid && |conflict;
	assign stall_id = hazard;

	// A waiting data port freezes the whole pipe
	assign advance_mem = !mem_busy;
	assign advance_ex = advance_mem;
	assign advance_id = advance_ex;
	assign flush = redirect && !mem_busy;

	// An empty IF/ID has nothing to gain from a clock while fetch waits
	assign advance_if = !mem_busy && (flush || !hazard) && !(fetch_busy && !dec_cw.valid);

endmodule : flow_control

/* rtl/instruction_decode.sv */
module instruction_decode (
	input logic clk,
	input logic rst_n,
	input lc3b_types_pkg::lc3b_word if_ir,
	input lc3b_types_pkg::lc3b_word if_pc,
	input logic if_valid,
	input logic advance_id,
	input logic stall_id,
	input logic flush,
	input lc3b_ctrl_pkg::mem_wb_t mem_wb,
	output lc3b_ctrl_pkg::id_ex_t id_ex,
	output lc3b_types_pkg::lc3b_nzp nzp,
	output lc3b_types_pkg::lc3b_reg dec_sr1,
	output lc3b_types_pkg::lc3b_reg dec_sr2,
	output lc3b_ctrl_pkg::lc3b_control dec_cw
);

	lc3b_types_pkg::lc3b_word regs [8];
	lc3b_types_pkg::lc3b_opcode opcode;
	lc3b_types_pkg::lc3b_word offset;
	lc3b_types_pkg::lc3b_word sr1_val;
	lc3b_types_pkg::lc3b_word sr2_val;
	logic wb_load;

	function automatic lc3b_types_pkg::lc3b_nzp gen_cc(input lc3b_types_pkg::lc3b_word value);
		gen_cc = {value[15], value == 16'h0000, !value[15] && value != 16'h0000};
	endfunction

	assign opcode = lc3b_types_pkg::lc3b_opcode'(if_ir[15:12]);
	assign dec_sr1 = if_ir[8:6];
	assign dec_sr2 = (opcode == lc3b_types_pkg::op_str) ? if_ir[11:9] : if_ir[2:0]; // STR data
	assign wb_load = mem_wb.cw.valid && mem_wb.cw.load_reg;

	// Writeback lands in the same cycle it is read
	assign sr1_val = (wb_load && mem_wb.cw.dest == dec_sr1) ? mem_wb.result : regs[dec_sr1];
	assign sr2_val = (wb_load && mem_wb.cw.dest == dec_sr2) ? mem_wb.result : regs[dec_sr2];

	always_comb begin
		dec_cw = lc3b_ctrl_pkg::bubble_cw;
		dec_cw.opcode = opcode;
		dec_cw.dest = if_ir[11:9];
		dec_cw.valid = if_valid;
		offset = {{11{if_ir[4]}}, if_ir[4:0]};
		case (opcode)
			lc3b_types_pkg::op_add: begin
				dec_cw.alu_op = lc3b_ctrl_pkg::alu_add;
				dec_cw.use_imm = if_ir[5];
				dec_cw.load_reg = 1'b1;
				dec_cw.set_cc = 1'b1;
			end
			lc3b_types_pkg::op_and: begin
				dec_cw.alu_op = lc3b_ctrl_pkg::alu_and;
				dec_cw.use_imm = if_ir[5];
				dec_cw.load_reg = 1'b1;
				dec_cw.set_cc = 1'b1;
			end
			lc3b_types_pkg::op_not: begin
				dec_cw.alu_op = lc3b_ctrl_pkg::alu_not;
				dec_cw.use_imm = if_ir[5];
				dec_cw.load_reg = 1'b1;
				dec_cw.set_cc = 1'b1;
			end
			lc3b_types_pkg::op_ldr: begin
				dec_cw.alu_op = lc3b_ctrl_pkg::alu_add;
				dec_cw.use_imm = 1'b1;
				dec_cw.load_reg = 1'b1;
				dec_cw.set_cc = 1'b1;
				dec_cw.mem_read = 1'b1;
				offset = {{9{if_ir[5]}}, if_ir[5:0], 1'b0}; // Word offset
			end
			lc3b_types_pkg::op_str: begin
				dec_cw.alu_op = lc3b_ctrl_pkg::alu_add;
				dec_cw.use_imm = 1'b1;
				dec_cw.mem_write = 1'b1;
				offset = {{9{if_ir[5]}}, if_ir[5:0], 1'b0};
			end
			lc3b_types_pkg::op_br: begin
				dec_cw.alu_op = lc3b_ctrl_pkg::alu_pass;
				dec_cw.is_branch = 1'b1;
				offset = {{6{if_ir[8]}}, if_ir[8:0], 1'b0};
			end
			default: begin
				dec_cw.valid = 1'b0; // Unsupported opcodes retire as bubbles
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			nzp <= lc3b_types_pkg::reset_nzp;
		end else begin
			if (wb_load)
				regs[mem_wb.cw.dest] <= mem_wb.result;
			if (mem_wb.cw.valid && mem_wb.cw.set_cc)
				nzp <= gen_cc(mem_wb.result);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (advance_id) begin
			id_ex.cw <= (stall_id || flush) ? lc3b_ctrl_pkg::bubble_cw : dec_cw;
			id_ex.pc <= if_pc;
			id_ex.sr1 <= sr1_val;
			id_ex.sr2 <= sr2_val;
			id_ex.offset <= offset;
		end
	end

endmodule : instruction_decode

/* rtl/instruction_fetch.sv */
module instruction_fetch (
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input lc3b_types_pkg::lc3b_word mem_rdata1,
	input logic advance_if,
	input logic flush,
	input logic redirect,
	input lc3b_types_pkg::lc3b_word target,
	output lc3b_types_pkg::lc3b_word mem_addr1,
	output logic mem_read1,
	output lc3b_types_pkg::lc3b_word if_ir,
	output lc3b_types_pkg::lc3b_word if_pc,
	output logic if_valid,
	output logic fetch_busy
);

	lc3b_types_pkg::lc3b_word pc;
	lc3b_types_pkg::lc3b_word word_buf;
	lc3b_types_pkg::lc3b_word redir_pc;
	logic have_word;
	logic drop;
	logic fetch_done;
	logic fetch_pending;
	logic word_ready;

	assign mem_addr1 = pc;
	assign fetch_done = mem_read1 && resp_a;
	assign fetch_pending = mem_read1 && !resp_a;
	assign word_ready = have_word || (fetch_done && !drop);
	assign fetch_busy = !word_ready || redirect; // Anything fetched now is on the wrong path

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= lc3b_types_pkg::reset_pc;
			mem_read1 <= 1'b0;
			have_word <= 1'b0;
			drop <= 1'b0;
			if_valid <= 1'b0;
		end else begin
			if (advance_if)
				if_valid <= word_ready && !flush;
			if (flush) begin
				have_word <= 1'b0;
				if (fetch_pending) begin
					drop <= 1'b1; // Let the open read finish at its old address
				end else begin
					pc <= target;
					mem_read1 <= 1'b1;
				end
			end else if (drop) begin
				if (resp_a) begin
					drop <= 1'b0;
					pc <= redir_pc;
				end
			end else if (word_ready) begin
				if (advance_if) begin
					pc <= pc + 16'd2;
					have_word <= 1'b0;
					mem_read1 <= 1'b1;
				end else if (!have_word) begin
					have_word <= 1'b1; // Park the word until decode takes it
					mem_read1 <= 1'b0;
				end
			end else begin
				mem_read1 <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (flush && fetch_pending)
			redir_pc <= target;
		if (fetch_done && !have_word)
			word_buf <= mem_rdata1;
		if (advance_if) begin
			if_ir <= have_word ? word_buf : mem_rdata1;
			if_pc <= pc + 16'd2;
		end
	end

endmodule : instruction_fetch

/* rtl/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

	typedef enum logic [1:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_not
	} alu_op_t;

	typedef struct packed {
		lc3b_types_pkg::lc3b_opcode opcode;
		alu_op_t alu_op;
		logic use_imm;
		logic load_reg;
		logic set_cc;
		logic mem_read;
		logic mem_write;
		logic is_branch;
		lc3b_types_pkg::lc3b_reg dest; // Carries the n/z/p mask on a branch
		logic valid;
	} lc3b_control;

	typedef struct packed {
		lc3b_control cw;
		lc3b_types_pkg::lc3b_word pc; // Address of the next instruction
		lc3b_types_pkg::lc3b_word sr1;
		lc3b_types_pkg::lc3b_word sr2;
		lc3b_types_pkg::lc3b_word offset;
	} id_ex_t;

	typedef struct packed {
		lc3b_control cw;
		lc3b_types_pkg::lc3b_word alu;
		lc3b_types_pkg::lc3b_word store_data;
	} ex_mem_t;

	typedef struct packed {
		lc3b_control cw;
		lc3b_types_pkg::lc3b_word result;
	} mem_wb_t;

	localparam lc3b_control bubble_cw = '0;

endpackage : lc3b_ctrl_pkg

/* rtl/lc3b_types_pkg.sv */
package lc3b_types_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // Bit 2 is n, bit 1 is z, bit 0 is p

	// Only the opcodes this core executes get a name
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001 // Encoded as XOR, so imm5 of all ones is the complement
	} lc3b_opcode;

	localparam lc3b_word reset_pc = 16'h0000;
	localparam lc3b_nzp reset_nzp = 3'b010; // Registers clear to zero, so z is set

endpackage : lc3b_types_pkg

/* rtl/memory_module.sv */
module memory_module (
	input logic clk,
	input logic rst_n,
	input lc3b_ctrl_pkg::ex_mem_t ex_mem,
	input logic resp_b,
	input lc3b_types_pkg::lc3b_word mem_rdata2,
	input logic advance_mem,
	output lc3b_types_pkg::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_types_pkg::lc3b_word mem_wdata2,
	output lc3b_ctrl_pkg::mem_wb_t mem_wb,
	output logic mem_busy
);

	logic mem_access;

	// EX/MEM is frozen while the port waits, so address and data stay put
	assign mem_addr2 = ex_mem.alu;
	assign mem_wdata2 = ex_mem.store_data;
	assign mem_read2 = ex_mem.cw.valid && ex_mem.cw.mem_read;
	assign mem_write2 = ex_mem.cw.valid && ex_mem.cw.mem_write;
	assign mem_access = mem_read2 || mem_write2;
	assign mem_busy = mem_access && !resp_b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else if (advance_mem) begin
			mem_wb.cw <= ex_mem.cw;
			mem_wb.result <= mem_read2 ? mem_rdata2 : ex_mem.alu;
		end
	end

endmodule : memory_module

/* tests/cpu_datapath_asserts.sv */
module cpu_datapath_asserts (
	input logic clk,
	input logic rst_n,
	input logic mem_read1,
	input logic mem_read2,
	input logic mem_write2,
	input logic resp_b,
	input lc3b_types_pkg::lc3b_word mem_addr2,
	input lc3b_types_pkg::lc3b_word mem_wdata2
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	property data_request_held;
		@(posedge clk) disable iff (!rst_n)
		(mem_read2 || mem_write2) && !resp_b |=>
			$stable(mem_addr2) && $stable(mem_wdata2) && $stable({mem_read2, mem_write2});
	endproperty

	request_held: assert property (data_request_held) else begin
		$error("data port request changed before resp_b");
		fail_count++;
	end

	read_write_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n) !(mem_read2 && mem_write2)) else begin
		$error("mem_read2 and mem_write2 high together");
		fail_count++;
	end

	quiet_in_reset: assert property (
		@(posedge clk) !rst_n |-> !mem_read1 && !mem_read2 && !mem_write2) else begin
		$error("memory request raised during reset");
		fail_count++;
	end

endmodule : cpu_datapath_asserts

/* tests/cpu_datapath_tb.sv */
module cpu_datapath_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		lc3b_types_pkg::lc3b_word addr;
		lc3b_types_pkg::lc3b_word data;
	} store_t;

	localparam int body_len = 60;
	localparam int store_timeout = 20000;
	localparam int halt_timeout = 400;
	localparam lc3b_types_pkg::lc3b_reg ptr_reg = 3'd6;
	localparam lc3b_types_pkg::lc3b_word data_base = 16'h000c; // Fits one ADD immediate

	logic clk;
	logic rst_n;
	logic resp_a;
	logic resp_b;
	logic mem_read1;
	logic mem_read2;
	logic mem_write2;
	lc3b_types_pkg::lc3b_word mem_addr1;
	lc3b_types_pkg::lc3b_word mem_rdata1;
	lc3b_types_pkg::lc3b_word mem_addr2;
	lc3b_types_pkg::lc3b_word mem_wdata2;
	lc3b_types_pkg::lc3b_word mem_rdata2;
	logic [1:0] delay_a;
	logic [1:0] delay_b;
	logic [31:0] lfsr = 32'he5ba;

	lc3b_types_pkg::lc3b_word prog [$];
	lc3b_types_pkg::lc3b_word model_mem [lc3b_types_pkg::lc3b_word];
	lc3b_types_pkg::lc3b_word model_regs [8];
	lc3b_types_pkg::lc3b_word halt_addr;
	store_t expected [$];
	store_t observed [$];
	lc3b_types_pkg::lc3b_word expected_loads [$];
	int expected_total;
	int loads_total;
	int loads_seen = 0;
	int taken_branches;
	int checks = 0;
	int errors = 0;

	cpu_datapath dut (.*);

	bind cpu_datapath cpu_datapath_asserts handshake_checks (.*);

	tb_memory imem (.clk, .rst_n, .read(mem_read1), .write(1'b0), .addr(mem_addr1),
		.wdata(16'h0000), .delay(delay_a), .resp(resp_a), .rdata(mem_rdata1));

	tb_memory dmem (.clk, .rst_n, .read(mem_read2), .write(mem_write2), .addr(mem_addr2),
		.wdata(mem_wdata2), .delay(delay_b), .resp(resp_b), .rdata(mem_rdata2));

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic lc3b_types_pkg::lc3b_word encode(input logic [3:0] op,
		input logic [2:0] f1, input logic [2:0] f2, input logic [5:0] low);
		return {op, f1, f2, low};
	endfunction

	task automatic build_program();
		lc3b_types_pkg::lc3b_word ir;
		lc3b_types_pkg::lc3b_word value;
		logic [2:0] kind;
		logic [2:0] dr;
		logic [2:0] sa;
		logic [4:0] low;
		logic [5:0] src2;
		int skip;
		for (int r = 0; r < 8; r++) begin
			low = (r == ptr_reg) ? data_base[4:0] : (5'(take_bits(4)) | 5'd1);
			prog.push_back(encode(lc3b_types_pkg::op_add, 3'(r), 3'(r), {1'b1, low}));
		end
		for (int i = 0; i < body_len; i++) begin
			kind = 3'(take_bits(3));
			dr = 3'(take_bits(3));
			sa = 3'(take_bits(3));
			low = 5'(take_bits(5));
			src2 = take_bits(1) != 0 ? {1'b1, low} : {3'b000, low[2:0]};
			if (dr == ptr_reg)
				dr = 3'd7; // The data pointer stays fixed
			case (kind)
				3'd2: ir = encode(lc3b_types_pkg::op_and, dr, sa, src2);
				3'd3: ir = encode(lc3b_types_pkg::op_not, dr, sa, src2);
				3'd4: ir = encode(lc3b_types_pkg::op_ldr, dr, ptr_reg, {3'b000, low[2:0]});
				3'd5: ir = encode(lc3b_types_pkg::op_str, sa, ptr_reg, {3'b000, low[2:0]});
				3'd6: begin
					skip = (low[1:0] < body_len - 1 - i) ? low[1:0] : body_len - 1 - i;
					ir = encode(lc3b_types_pkg::op_br, sa, 3'b000, 6'(skip)); // Never past the body
				end
				default: ir = encode(lc3b_types_pkg::op_add, dr, sa, src2);
			endcase
			prog.push_back(ir);
		end
		for (int r = 0; r < 8; r++)
			prog.push_back(encode(lc3b_types_pkg::op_str, 3'(r), ptr_reg, 6'(8 + r)));
		halt_addr = 16'(2 * prog.size());
		prog.push_back(encode(lc3b_types_pkg::op_br, 3'b111, 3'b111, 6'h3f));
		for (int i = 0; i < prog.size(); i++)
			imem.mem[16'(2 * i)] = prog[i];
		for (int w = 0; w < 16; w++) begin
			value = take_bits(16);
			dmem.mem[data_base + 16'(2 * w)] = value;
			model_mem[data_base + 16'(2 * w)] = value;
		end
	endtask

	task automatic run_model();
		lc3b_types_pkg::lc3b_word pc;
		lc3b_types_pkg::lc3b_word ir;
		lc3b_types_pkg::lc3b_word a;
		lc3b_types_pkg::lc3b_word b;
		lc3b_types_pkg::lc3b_word addr;
		lc3b_types_pkg::lc3b_word res;
		lc3b_types_pkg::lc3b_nzp nzp;
		logic writes;
		int steps;
		pc = lc3b_types_pkg::reset_pc;
		nzp = 3'b010; // All registers start at zero
		steps = 0;
		taken_branches = 0;
		res = '0;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		while (pc != halt_addr && steps < 1000) begin
			ir = prog[pc[15:1]];
			pc = pc + 16'd2;
			a = model_regs[ir[8:6]];
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
			addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};
			writes = 1'b1;
			case (ir[15:12])
				lc3b_types_pkg::op_add: res = a + b;
				lc3b_types_pkg::op_and: res = a & b;
				lc3b_types_pkg::op_not: res = a ^ b; // NOT is the all ones immediate
				lc3b_types_pkg::op_ldr: begin
					res = model_mem[addr];
					expected_loads.push_back(addr);
				end
				lc3b_types_pkg::op_str: begin
					writes = 1'b0;
					model_mem[addr] = model_regs[ir[11:9]];
					expected.push_back({addr, model_regs[ir[11:9]]});
				end
				default: begin
					writes = 1'b0;
					if (|(ir[11:9] & nzp)) begin
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
						taken_branches++;
					end
				end
			endcase
			if (writes) begin
				model_regs[ir[11:9]] = res;
				nzp = {res[15], res == 16'h0000, !res[15] && res != 16'h0000};
			end
			steps++;
		end
	endtask

	task automatic check_word(input string name, input lc3b_types_pkg::lc3b_word got,
		input lc3b_types_pkg::lc3b_word want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[FAIL] %0t %s: expected %h, got %h", $time, name, want, got);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %-14s %s", name, (errors == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		delay_a <= 2'(take_bits(2));
		delay_b <= 2'(take_bits(2));
	end

	// The store completes at the next rising edge
	always @(negedge clk) begin : store_monitor
		store_t got;
		store_t want;
		if (rst_n && mem_write2 && resp_b) begin
			got = {mem_addr2, mem_wdata2};
			observed.push_back(got);
			if (expected.size() == 0) begin
				errors++;
				$display("unexpected extra store of %h to %h at %0t", got.data, got.addr,
					$time);
			end else begin
				want = expected.pop_front();
				check_word("mem_addr2", got.addr, want.addr);
				check_word("mem_wdata2", got.data, want.data);
			end
		end
	end

	always @(negedge clk) begin : load_monitor
		if (rst_n && mem_read2 && resp_b) begin
			loads_seen++;
			if (expected_loads.size() == 0) begin
				errors++;
				$display("unexpected extra load from %h at %0t", mem_addr2, $time);
			end else begin
				check_word("mem_addr2", mem_addr2, expected_loads.pop_front());
			end
		end
	end

	initial begin : main
		int mark;
		int cycles;
		int seen;
		rst_n = 1'b0;
		delay_a = 2'd0;
		delay_b = 2'd0;
		build_program();
		run_model();
		expected_total = expected.size();
		loads_total = expected_loads.size();
		$display("program of %0d words, %0d stores, %0d loads and %0d taken branches expected",
			prog.size(), expected_total, loads_total, taken_branches);
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		mark = errors;
		cycles = 0;
		while (observed.size() < expected_total && cycles < store_timeout) begin
			@(posedge clk);
			cycles++;
		end
		if (observed.size() < expected_total) begin
			errors++;
			$display("timeout with %0d of %0d stores seen", observed.size(), expected_total);
		end
		report_test("store_stream", mark);

		mark = errors;
		if (observed.size() < 8) begin
			errors++;
			$display("fewer than eight stores seen, so the register dump is missing");
		end else begin
			for (int r = 0; r < 8; r++)
				check_word($sformatf("R%0d", r), observed[observed.size() - 8 + r].data,
					model_regs[r]);
		end
		report_test("final_regs", mark);

		mark = errors;
		seen = 0;
		cycles = 0;
		while (seen < 2 && cycles < halt_timeout) begin
			@(negedge clk);
			if (mem_read1 && resp_a && mem_addr1 == halt_addr)
				seen++; // The halt branch keeps fetching itself
			cycles++;
		end
		checks++;
		assert (seen == 2) else begin
			errors++;
			$display("fetch did not settle at halt address %h in time", halt_addr);
		end
		report_test("halt", mark);

		// Stores that slip out while the halt loop runs are counted too
		mark = errors;
		checks++;
		assert (observed.size() == expected_total) else begin
			errors++;
			$display("[FAIL] %0t store_count: expected %0d, got %0d", $time, expected_total,
				observed.size());
		end
		report_test("store_count", mark);

		mark = errors;
		checks++;
		assert (loads_seen == loads_total) else begin
			errors++;
			$display("[FAIL] %0t load_count: expected %0d, got %0d", $time, loads_total,
				loads_seen);
		end
		report_test("load_count", mark);

		mark = errors;
		errors += dut.handshake_checks.fail_count;
		report_test("handshake", mark);

		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule : cpu_datapath_tb

/* tests/tb_memory.sv */
module tb_memory (
	input logic clk,
	input logic rst_n,
	input logic read,
	input logic write,
	input lc3b_types_pkg::lc3b_word addr,
	input lc3b_types_pkg::lc3b_word wdata,
	input logic [1:0] delay,
	output logic resp,
	output lc3b_types_pkg::lc3b_word rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	lc3b_types_pkg::lc3b_word mem [lc3b_types_pkg::lc3b_word]; // Keyed by byte address
	logic [1:0] waited;

	function automatic lc3b_types_pkg::lc3b_word read_word(input lc3b_types_pkg::lc3b_word a);
		if (mem.exists(a))
			return mem[a];
		return {a[7:0], a[15:8]} ^ 16'hf00f; // Untouched words still differ for every address
	endfunction

	initial begin
		resp = 1'b0;
		rdata = '0;
		waited = '0;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp <= 1'b0;
			rdata <= '0;
			waited <= '0;
		end else if (resp) begin
			resp <= 1'b0; // This edge completes the transaction
			waited <= '0;
			if (write)
				mem[addr] = wdata;
		end else if (read || write) begin
			if (waited >= delay) begin
				resp <= 1'b1;
				rdata <= read_word(addr);
			end else begin
				waited <= waited + 2'd1;
			end
		end
	end

endmodule : tb_memory
